//--- sim/fpAddInput.txt
// Columns: operand a, operand b, expected sum, all as hex words
// Sums from a reference float model, nearest even, subnormals flushed to zero
3F800000 3F800000 40000000
3F800000 35800000 3F800008
3F800000 30800000 3F800000
3FFFFFFF 3FFFFFFF 407FFFFF
3DCCCCCD 3E4CCCCD 3E99999A
3F800001 BF800000 34000000
3F800000 BF800000 00000000
40000000 BFFFFFFF 34000000
3F800000 B0800000 3F800000
80000000 80000000 80000000
3F800001 40000000 40400000
3F800003 40000000 40400002
3F800003 40800000 40A00001
3F800000 33800000 3F800000
3F800000 33800001 3F800001
3F800001 3F800002 40000002
3FFFFFFF 33800000 40000000
3F800000 B3000000 3F800000
7FC00000 3F800000 7FC00000
3F800000 7F800001 7FC00000
7F800000 FF800000 7FC00000
40A00000 FF800000 FF800000
7F7FFFFF 7F7FFFFF 7F800000
FF7FFFFF FF7FFFFF FF800000
7F7FFFFF 73000000 7F800000
00000001 3F800000 3F800000
807FFFFF BF800000 BF800000
80800001 00800000 80000000

//--- flist.f
src/FpAddPkg.sv
src/FpUnpack.sv
src/FpAlign.sv
src/FpAddNorm.sv
src/FpRoundPack.sv
src/FpAdder.sv
sim/FpAdderTb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP   = FpAdderTb
FLIST = flist.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/FpAdderTb.sv
// Floating-point adder testbench
`timescale 1ns/1ps

module FpAdderTb;
  import FpAddPkg::*;

  localparam int ClkPeriod  = 8;
  localparam int Latency    = 4;    // Cycles from drive to result
  localparam int BurstLen   = 8;    // Leading pairs sent back to back
  localparam int DrainLimit = 200;  // Cycles

  logic  clk;
  logic  rstN;
  logic  inValid;
  FpWord a, b;
  logic  outValid;
  FpWord result;

  FpWord vecA[$], vecB[$], vecSum[$];  // Whole vector file
  FpWord pendQ[$];                     // Driven, not yet sampled
  FpWord expQ[$], opAQ[$], opBQ[$];    // In flight inside the DUT
  int    launchQ[$];
  int    cycle = 0;
  int    seed;
  int    checked = 0;
  int    valueErrors = 0;
  int    latencyErrors = 0;
  int    protocolErrors = 0;
  logic  timedOut;

  FpAdder UUT (
    .clk(clk), .rstN(rstN), .inValid(inValid), .a(a), .b(b),
    .outValid(outValid), .result(result)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;  // Rising edges so far

  // Lines that do not parse as three hex words are comments
  task automatic readVectors();
    int    fd;
    int    n;
    string line;
    FpWord va, vb, vs;
    fd = $fopen("sim/fpAddInput.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file sim/fpAddInput.txt");
      protocolErrors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && $sscanf(line, "%h %h %h", va, vb, vs) == 3) begin
        vecA.push_back(va);
        vecB.push_back(vb);
        vecSum.push_back(vs);
      end
    end
    $fclose(fd);
  endtask

  // ==============================
  // Input monitor and output checker
  // ==============================
  always @(posedge clk) begin
    if (rstN === 1'b1 && inValid === 1'b1) begin
      if (pendQ.size() > 0) begin
        expQ.push_back(pendQ.pop_front());
        opAQ.push_back(a);
        opBQ.push_back(b);
        launchQ.push_back(cycle);  // Edges before the sampling one
      end else begin
        $display("Input strobe at %0t with no vector behind it", $time);
        protocolErrors++;
      end
    end
  end

  always @(negedge clk) begin
    FpWord expSum, opA, opB;
    int    launch;
    if (cycle > 0) begin
      assert (!$isunknown(outValid)) else begin
        $display("outValid is unknown at %0t", $time);
        protocolErrors++;
      end
    end
    if (outValid === 1'b1) begin
      assert (expQ.size() > 0) else begin
        $display("Result strobe at %0t with no input outstanding", $time);
        protocolErrors++;
      end
      if (expQ.size() > 0) begin
        expSum = expQ.pop_front();
        opA    = opAQ.pop_front();
        opB    = opBQ.pop_front();
        launch = launchQ.pop_front();
        checked++;
        assert (result === expSum) else begin
          $display("[ERROR] %0d ns: %h + %h expected %h, got %h",
                   $time, opA, opB, expSum, result);
          valueErrors++;
        end
        assert (cycle - launch == Latency) else begin
          $display("[ERROR] %0d ns: %h + %h came after %0d cycles, expected %0d",
                   $time, opA, opB, cycle - launch, Latency);
          latencyErrors++;
        end
      end
    end
  end

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    int k;
    int gap;
    int waited;
    clk     = 1'b0;
    rstN    = 1'b0;
    inValid = 1'b0;
    a       = '0;
    b       = '0;
    seed    = 32'h8200a305;
    readVectors();
    assert (vecA.size() > 0) else begin
      $display("No test vectors were read");
      protocolErrors++;
    end
    repeat (10) @(posedge clk);  // Reset held 10 cycles
    @(negedge clk);
    rstN = 1'b1;
    for (k = 0; k < vecA.size(); k++) begin
      pendQ.push_back(vecSum[k]);
      a       = vecA[k];
      b       = vecB[k];
      inValid = 1'b1;
      @(negedge clk);
      inValid = 1'b0;
      if (k >= BurstLen) begin
        gap = $random(seed) & 1;  // 0 or 1 idle cycle
        repeat (gap) @(negedge clk);
      end
    end
    // Drain, bounded
    waited = 0;
    while ((expQ.size() > 0 || pendQ.size() > 0) && waited < DrainLimit) begin
      @(negedge clk);
      waited++;
    end
    timedOut = (expQ.size() > 0) || (pendQ.size() > 0);
    if (timedOut) begin
      $display("Timed out with %0d results still missing", expQ.size() + pendQ.size());
    end
    repeat (Latency + 2) @(negedge clk);  // Catch stray strobes
    assert (checked == vecA.size()) else begin
      $display("Saw %0d results for %0d inputs", checked, vecA.size());
      protocolErrors++;
    end
    $display("Checked %0d results: %0d value, %0d latency, %0d protocol errors",
             checked, valueErrors, latencyErrors, protocolErrors);
    if (valueErrors + latencyErrors + protocolErrors == 0 && !timedOut) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- src/FpAdder.sv
// Pipelined single-precision adder
`timescale 1ns/1ps

module FpAdder (
  input  logic            clk,
  input  logic            rstN,
  input  logic            inValid,
  input  FpAddPkg::FpWord a,
  input  FpAddPkg::FpWord b,
  output logic            outValid,
  output FpAddPkg::FpWord result
);
  import FpAddPkg::*;

  // Stage handoff
  logic     unpackValid, alignValid, normValid;
  UnpackedT unpacked;
  AlignedT  aligned;
  NormT     norm;

  // ==============================
  // Four registered stages
  // ==============================
  FpUnpack unpackStage (
    .clk(clk), .rstN(rstN), .inValid(inValid), .a(a), .b(b),
    .outValid(unpackValid), .unpacked(unpacked)
  );

  FpAlign alignStage (
    .clk(clk), .rstN(rstN), .inValid(unpackValid), .unpacked(unpacked),
    .outValid(alignValid), .aligned(aligned)
  );

  FpAddNorm addNormStage (
    .clk(clk), .rstN(rstN), .inValid(alignValid), .aligned(aligned),
    .outValid(normValid), .norm(norm)
  );

  FpRoundPack roundPackStage (  // Result registered here
    .clk(clk), .rstN(rstN), .inValid(normValid), .norm(norm),
    .outValid(outValid), .result(result)
  );

endmodule

//--- src/FpRoundPack.sv
// Adder stage 4 round and pack
`timescale 1ns/1ps

module FpRoundPack (
  input  logic            clk,
  input  logic            rstN,
  input  logic            inValid,
  input  FpAddPkg::NormT  norm,
  output logic            outValid,
  output FpAddPkg::FpWord result
);
  import FpAddPkg::*;

  logic               lsb, guard, restSticky;
  logic               roundUp;
  logic [ManBits+1:0] rounded;  // Hidden bit plus carry out
  logic [ManBits-1:0] fracOut;
  logic signed [9:0]  expR;     // Exponent after rounding carry
  FpWord              nextR;

  // ==============================
  // Round to nearest even
  // ==============================
  assign lsb        = norm.man[GrsBits];
  assign guard      = norm.man[GrsBits-1];
  assign restSticky = |norm.man[GrsBits-2:0];
  assign roundUp    = guard & (restSticky | lsb);  // Ties go to even

  assign rounded = {1'b0, norm.man[ManBits+GrsBits:GrsBits]}
                 + {{(ManBits+1){1'b0}}, roundUp};

  // Carry out means 1.000, shift down one
  assign fracOut = rounded[ManBits+1] ? rounded[ManBits:1] : rounded[ManBits-1:0];
  assign expR    = $signed(norm.exp) + $signed({9'b0, rounded[ManBits+1]});

  // Pack
  always_comb begin
    if (norm.special.isSpecial) begin
      nextR = norm.special.word;                          // NaN or inf from stage 1
    end else if (norm.isZero || expR <= 10'sd0) begin
      nextR = {norm.sign, {(ExpBits+ManBits){1'b0}}};     // Signed zero, tiny flushed
    end else if (expR >= $signed({2'b00, ExpMax})) begin
      nextR = {norm.sign, ExpMax, {ManBits{1'b0}}};       // Overflow to inf
    end else begin
      nextR = {norm.sign, expR[ExpBits-1:0], fracOut};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) outValid <= 1'b0;
    else       outValid <= inValid;
  end

  always_ff @(posedge clk) result <= nextR;

endmodule

//--- src/FpAddNorm.sv
// Adder stage 3 add and normalize
`timescale 1ns/1ps

module FpAddNorm (
  input  logic              clk,
  input  logic              rstN,
  input  logic              inValid,
  input  FpAddPkg::AlignedT aligned,
  output logic              outValid,
  output FpAddPkg::NormT    norm
);
  import FpAddPkg::*;

  SumManT            sum;
  logic              carry;     // Same-sign add overflowed
  WideManT           low;       // Sum without carry bit
  logic [4:0]        lzc;
  logic signed [9:0] expIn;
  NormT              nextN;

  // Leading zeros, 27 when v is zero
  function automatic logic [4:0] countLz(input WideManT v);
    logic [4:0] n;
    n = 5'd27;
    for (int i = 0; i < $bits(WideManT); i++) begin
      if (v[i]) n = 5'($bits(WideManT) - 1 - i);  // Highest set bit wins
    end
    return n;
  endfunction

  // ==============================
  // Significand add or subtract
  // ==============================
  always_comb begin
    if (aligned.effSub) begin
      sum = {1'b0, aligned.bigMan} - {1'b0, aligned.alignedSmall};
    end else begin
      sum = {1'b0, aligned.bigMan} + {1'b0, aligned.alignedSmall};
    end
  end

  assign carry = sum[$bits(SumManT)-1];
  assign low   = sum[$bits(WideManT)-1:0];
  assign lzc   = countLz(low);
  assign expIn = $signed({2'b00, aligned.exp});

  // Normalize
  always_comb begin
    nextN.special = aligned.special;
    nextN.isZero  = (sum == '0);  // Exact cancellation
    if (carry) begin
      nextN.man = {sum[$bits(SumManT)-1:2], |sum[1:0]};  // Keep sticky
      nextN.exp = expIn + 10'sd1;
    end else begin
      nextN.man = low << lzc;  // Hidden bit to the top
      nextN.exp = expIn - $signed({5'b00000, lzc});
    end
    // RNE zero is negative only for two negatives
    if (nextN.isZero) nextN.sign = aligned.sign & ~aligned.effSub;
    else              nextN.sign = aligned.sign;
  end

  always_ff @(posedge clk) begin
    if (!rstN) outValid <= 1'b0;
    else       outValid <= inValid;
  end

  always_ff @(posedge clk) norm <= nextN;

  // Stage 1 ordering keeps the difference nonnegative
  assert property (@(posedge clk) disable iff (!rstN)
    (inValid && aligned.effSub && !aligned.special.isSpecial)
      |-> (aligned.bigMan >= aligned.alignedSmall))
    else $error("FpAddNorm: negative significand difference");

endmodule

//--- src/FpAlign.sv
// Adder stage 2 alignment
`timescale 1ns/1ps

module FpAlign (
  input  logic               clk,
  input  logic               rstN,
  input  logic               inValid,
  input  FpAddPkg::UnpackedT unpacked,
  output logic               outValid,
  output FpAddPkg::AlignedT  aligned
);
  import FpAddPkg::*;

  WideManT smallExt;   // Small significand with empty GRS
  WideManT shifted;
  WideManT lostMask;   // Bits that fall off the right
  logic    sticky;
  logic    zeroSmall;
  AlignedT nextA;

  assign smallExt  = {unpacked.smallMan, {GrsBits{1'b0}}};
  assign zeroSmall = unpacked.zeroA | unpacked.zeroB;  // Zero is always the small one

  // ==============================
  // Right shift with sticky
  // ==============================
  always_comb begin
    if (unpacked.expDiff >= ExpT'($bits(WideManT))) begin
      shifted  = '0;  // Whole operand goes to sticky
      lostMask = '1;
    end else begin
      shifted  = smallExt >> unpacked.expDiff;
      lostMask = (WideManT'(1) << unpacked.expDiff) - WideManT'(1);
    end
    sticky = |(smallExt & lostMask);
  end

  always_comb begin
    nextA.sign    = unpacked.bigSign;
    nextA.effSub  = unpacked.effSub;
    nextA.exp     = unpacked.bigExp;  // Result starts at big exponent
    nextA.bigMan  = {unpacked.bigMan, {GrsBits{1'b0}}};
    nextA.special = unpacked.special;
    if (zeroSmall) begin
      nextA.alignedSmall = '0;
    end else begin
      nextA.alignedSmall = {shifted[$bits(WideManT)-1:1], shifted[0] | sticky};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) outValid <= 1'b0;
    else       outValid <= inValid;
  end

  always_ff @(posedge clk) aligned <= nextA;

endmodule

//--- src/FpUnpack.sv
// Adder stage 1 unpack
`timescale 1ns/1ps

module FpUnpack (
  input  logic               clk,
  input  logic               rstN,
  input  logic               inValid,
  input  FpAddPkg::FpWord    a,
  input  FpAddPkg::FpWord    b,
  output logic               outValid,
  output FpAddPkg::UnpackedT unpacked
);
  import FpAddPkg::*;

  logic               signA, signB;
  ExpT                expA, expB;
  logic [ManBits-1:0] fracA, fracB;
  logic               zeroA, zeroB;
  logic               nanA, nanB, infA, infB;
  ManT                manA, manB;
  logic               aBigger;  // A has the larger magnitude
  UnpackedT           nextU;

  // Field split
  assign signA = a[ExpBits+ManBits];
  assign signB = b[ExpBits+ManBits];
  assign expA  = a[ExpBits+ManBits-1:ManBits];
  assign expB  = b[ExpBits+ManBits-1:ManBits];
  assign fracA = a[ManBits-1:0];
  assign fracB = b[ManBits-1:0];

  assign zeroA = (expA == '0);  // Subnormals flush here
  assign zeroB = (expB == '0);
  assign manA  = zeroA ? '0 : {1'b1, fracA};  // Restore hidden bit
  assign manB  = zeroB ? '0 : {1'b1, fracB};

  // Special classes
  assign nanA = (expA == ExpMax) && (fracA != '0);
  assign nanB = (expB == ExpMax) && (fracB != '0);
  assign infA = (expA == ExpMax) && (fracA == '0);
  assign infB = (expB == ExpMax) && (fracB == '0);

  // Exponent first, then mantissa
  assign aBigger = {expA, manA} >= {expB, manB};

  always_comb begin
    nextU.bigSign  = aBigger ? signA : signB;
    nextU.effSub   = signA ^ signB;
    nextU.bigExp   = aBigger ? expA : expB;
    nextU.expDiff  = aBigger ? expA - expB : expB - expA;
    nextU.bigMan   = aBigger ? manA : manB;
    nextU.smallMan = aBigger ? manB : manA;
    nextU.zeroA    = zeroA;
    nextU.zeroB    = zeroB;
    nextU.special.isSpecial = nanA | nanB | infA | infB;
    if (nanA || nanB || (infA && infB && (signA != signB))) begin
      nextU.special.word = CanonNan;  // NaN in, or inf minus inf
    end else if (infA) begin
      nextU.special.word = a;
    end else begin
      nextU.special.word = b;         // Inf B, or unused
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) outValid <= 1'b0;
    else       outValid <= inValid;
  end

  always_ff @(posedge clk) unpacked <= nextU;  // Payload, no reset

  // Gap below big exponent means no wrap
  assert property (@(posedge clk) disable iff (!rstN)
    outValid |-> (unpacked.bigExp >= unpacked.expDiff))
    else $error("FpUnpack: exponent difference wrapped");

endmodule

//--- src/FpAddPkg.sv
// Single-precision adder types
package FpAddPkg;

  // ==============================
  // Format constants
  // ==============================
  localparam int ManBits = 23;  // Stored fraction bits
  localparam int ExpBits = 8;   // Biased exponent bits
  localparam int GrsBits = 3;   // Guard, round, sticky

  // Word and field vectors
  typedef logic [ExpBits+ManBits:0]   FpWord;    // Sign, exponent, fraction
  typedef logic [ExpBits-1:0]         ExpT;      // Biased exponent
  typedef logic [ManBits:0]           ManT;      // Hidden bit on top
  typedef logic [ManBits+GrsBits:0]   WideManT;  // Significand plus GRS
  typedef logic [ManBits+GrsBits+1:0] SumManT;   // Extra carry bit

  localparam ExpT   ExpMax   = 8'd255;          // Inf and NaN exponent
  localparam FpWord CanonNan = 32'h7FC0_0000;   // Canonical quiet NaN

  // ==============================
  // Stage payloads
  // ==============================
  typedef struct packed {
    logic  isSpecial;  // Result already decided in stage 1
    FpWord word;       // NaN or infinity to emit
  } SpecialT;

  // Stage 1 to stage 2
  typedef struct packed {
    logic    bigSign;   // Sign of larger magnitude
    logic    effSub;    // Operand signs differ
    ExpT     bigExp;
    ExpT     expDiff;   // Always nonnegative
    ManT     bigMan;
    ManT     smallMan;
    logic    zeroA;     // Flushed or true zero
    logic    zeroB;
    SpecialT special;
  } UnpackedT;

  typedef struct packed {
    logic    sign;
    logic    effSub;
    ExpT     exp;
    WideManT bigMan;        // GRS bits all clear
    WideManT alignedSmall;  // Sticky folded into bit 0
    SpecialT special;
  } AlignedT;

  // Stage 3 to stage 4
  typedef struct packed {
    logic              sign;
    logic signed [9:0] exp;  // Room for under and overflow
    WideManT           man;  // Hidden bit at top after normalize
    logic              isZero;
    SpecialT           special;
  } NormT;

endpackage
